//--- project.f
+incdir+test
src/chip_pkg.sv
src/apb_pkg.sv
src/octal_register.sv
src/transparent_latch.sv
src/jk_flag_pair.sv
src/chip_bank_regs.sv
src/chip_bank_top.sv
test/tb_chip_bank.sv

//--- src/apb_pkg.sv
package apb_pkg;

   ////////////////////////////////////////////////
   // APB bus types
   ////////////////////////////////////////////////

   typedef logic [7:0]  addr_t;   // Byte address, word aligned offsets
   typedef logic [31:0] data_t;

   // Master to slave
   typedef struct packed {
      logic  psel;
      logic  penable;
      logic  pwrite;
      addr_t paddr;
      data_t pwdata;
   } apb_req_t;

   // Slave to master
   typedef struct packed {
      data_t prdata;
      logic  pready;    // Tied high, no wait states
      logic  pslverr;   // Unmapped offset
   } apb_rsp_t;

   ////////////////////////////////////////////////
   // Register map
   ////////////////////////////////////////////////

   localparam addr_t REG_A    = 8'h00;  // RW, register A contents
   localparam addr_t REG_B    = 8'h04;  // RW, register B stored value
   localparam addr_t BUS_CTRL = 8'h08;  // RW, [1:0] bus_sel, [2] latch_en
   localparam addr_t CLEAR_A  = 8'h0C;  // WO, any write clears A
   localparam addr_t JK_LEVEL = 8'h10;  // RW, nibble per flop
   localparam addr_t JK_PULSE = 8'h14;  // WO, [1:0] clock edge per flop
   localparam addr_t STATUS   = 8'h18;  // RO, bus, latch and flags

   // STATUS field positions
   localparam int STAT_BUS_LSB   = 0;
   localparam int STAT_LATCH_LSB = 8;
   localparam int STAT_FLAG_LSB  = 16;

endpackage

//--- src/chip_bank_regs.sv
`timescale 1ns/1ps

// APB register block for the chip bank
// Decodes accesses into storage strobes, keeps BUS_CTRL and JK_LEVEL,
// drives the data bus mux and builds the readback
module chip_bank_regs #(
   parameter int BUS_W = 8
) (
   input  logic                     clk,
   input  logic                     rst,
   input  apb_pkg::apb_req_t        apb_req,
   output apb_pkg::apb_rsp_t        apb_rsp,
   output logic                     a_load,
   output logic                     a_clear,
   output logic                     b_load,
   output logic [BUS_W-1:0]         a_wdata,
   output logic [BUS_W-1:0]         b_wdata,
   output logic                     latch_en,
   output chip_pkg::jk_ctrl_t [1:0] jk_ctrl,
   output logic [1:0]               jk_clk,
   input  logic [BUS_W-1:0]         a_q,
   input  logic [BUS_W-1:0]         b_q,      // Already inverted by the 564
   input  logic [BUS_W-1:0]         latch_q,
   input  chip_pkg::flag_t [1:0]    flags,
   output logic [BUS_W-1:0]         data_bus
);

   logic                     acc;        // Access phase
   logic                     wr_en;
   logic                     rd_en;
   logic                     mapped;
   chip_pkg::bus_sel_t       bus_sel;
   chip_pkg::jk_ctrl_t [1:0] jk_level;
   logic [BUS_W-1:0]         b_val;      // Stored value of B
   logic [3:0]               flag_bits;
   apb_pkg::data_t           status;
   apb_pkg::data_t           rd_data;

   ////////////////////////////////////////////////
   // Access decode
   ////////////////////////////////////////////////

   assign acc   = apb_req.psel && apb_req.penable;
   assign wr_en = acc && apb_req.pwrite;
   assign rd_en = acc && !apb_req.pwrite;

   // Storage strobes, live only in the access cycle
   // so the chip loads on the edge that ends it
   assign a_load  = wr_en && (apb_req.paddr == apb_pkg::REG_A);
   assign a_clear = wr_en && (apb_req.paddr == apb_pkg::CLEAR_A);
   assign b_load  = wr_en && (apb_req.paddr == apb_pkg::REG_B);

   assign a_wdata = apb_req.pwdata[BUS_W-1:0];
   assign b_wdata = apb_req.pwdata[BUS_W-1:0];

   ////////////////////////////////////////////////
   // Control registers
   ////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst) begin
         bus_sel  <= chip_pkg::SEL_NONE;
         latch_en <= 1'b0;
         jk_level <= {chip_pkg::JK_CTRL_IDLE, chip_pkg::JK_CTRL_IDLE};
         jk_clk   <= 2'b00;
      end else begin
         jk_clk <= 2'b00;   // Pulse lasts one cycle
         if (wr_en) begin
            case (apb_req.paddr)
               apb_pkg::BUS_CTRL: begin
                  bus_sel  <= apb_req.pwdata[1:0];
                  latch_en <= apb_req.pwdata[2];
               end
               apb_pkg::JK_LEVEL: jk_level <= apb_req.pwdata[7:0];  // Flop 0 in [3:0]
               apb_pkg::JK_PULSE: jk_clk   <= apb_req.pwdata[1:0];  // Edge lands next cycle
               default: ;    // Strobed regs, STATUS and holes
            endcase
         end
      end
   end

   assign jk_ctrl = jk_level;

   ////////////////////////////////////////////////
   // Data bus
   ////////////////////////////////////////////////

   // Stands in for the tri-state bus, nobody driving reads as pull-ups
   always_comb begin
      case (bus_sel)
         chip_pkg::SEL_A:     data_bus = a_q;
         chip_pkg::SEL_B:     data_bus = b_q;      // Complement of stored B
         chip_pkg::SEL_LATCH: data_bus = latch_q;
         default:             data_bus = '1;       // SEL_NONE
      endcase
   end

   ////////////////////////////////////////////////
   // Readback
   ////////////////////////////////////////////////

   assign b_val = ~b_q;   // Undo the 564 inversion

   // Flags as q0, qn0, q1, qn1 from bit 16 up
   assign flag_bits = {flags[1].qn, flags[1].q, flags[0].qn, flags[0].q};

   always_comb begin
      status = '0;
      status[apb_pkg::STAT_BUS_LSB   +: 8] = chip_pkg::octal_t'(data_bus);
      status[apb_pkg::STAT_LATCH_LSB +: 8] = chip_pkg::octal_t'(latch_q);
      status[apb_pkg::STAT_FLAG_LSB  +: 4] = flag_bits;
   end

   always_comb begin
      rd_data = '0;
      mapped  = 1'b1;
      case (apb_req.paddr)
         apb_pkg::REG_A:    rd_data = apb_pkg::data_t'(a_q);
         apb_pkg::REG_B:    rd_data = apb_pkg::data_t'(b_val);
         apb_pkg::BUS_CTRL: rd_data = apb_pkg::data_t'({latch_en, bus_sel});
         apb_pkg::JK_LEVEL: rd_data = apb_pkg::data_t'(jk_level);
         apb_pkg::STATUS:   rd_data = status;
         apb_pkg::CLEAR_A,
         apb_pkg::JK_PULSE: rd_data = '0;      // Write only, read as zero
         default:           mapped  = 1'b0;
      endcase
   end

   // No wait states, error only on a hole in the map
   assign apb_rsp.prdata  = rd_en ? rd_data : '0;
   assign apb_rsp.pready  = 1'b1;
   assign apb_rsp.pslverr = acc && !mapped;

   ////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////

   // Access phase only exists inside a selected transfer
   a_penable_needs_psel : assert property (
      @(posedge clk) disable iff (!rst)
      apb_req.penable |-> apb_req.psel
   ) else $error("chip_bank_regs: penable without psel");

endmodule

//--- src/chip_bank_top.sv
`timescale 1ns/1ps

// Chip bank top level
// APB register block steering the 273, 564, 373 and 112 models
module chip_bank_top #(
   parameter int BUS_W = 8
) (
   input  logic                   clk,
   input  logic                   rst,
   input  apb_pkg::apb_req_t      apb_req,
   output apb_pkg::apb_rsp_t      apb_rsp,
   input  logic [BUS_W-1:0]       bus_in,
   input  logic                   capture,
   output logic [BUS_W-1:0]       data_bus,
   output chip_pkg::flag_t [1:0]  flags
);

   // Regs block to storage
   logic                     a_load;
   logic                     a_clear;
   logic                     b_load;
   logic [BUS_W-1:0]         a_wdata;
   logic [BUS_W-1:0]         b_wdata;
   logic                     latch_en;
   chip_pkg::jk_ctrl_t [1:0] jk_ctrl;
   logic [1:0]               jk_clk;

   // Storage back to the bus mux
   logic [BUS_W-1:0]         a_q;
   logic [BUS_W-1:0]         b_q;
   logic [BUS_W-1:0]         latch_q;

   chip_bank_regs #(.BUS_W(BUS_W)) u_regs (
      .clk      (clk),
      .rst      (rst),
      .apb_req  (apb_req),
      .apb_rsp  (apb_rsp),
      .a_load   (a_load),
      .a_clear  (a_clear),
      .b_load   (b_load),
      .a_wdata  (a_wdata),
      .b_wdata  (b_wdata),
      .latch_en (latch_en),
      .jk_ctrl  (jk_ctrl),
      .jk_clk   (jk_clk),
      .a_q      (a_q),
      .b_q      (b_q),
      .latch_q  (latch_q),
      .flags    (flags),
      .data_bus (data_bus)
   );

   // 74x273, also captures straight from bus_in
   octal_register #(.BUS_W(BUS_W), .INVERT(1'b0)) reg_a (
      .clk     (clk),
      .rst     (rst),
      .load    (a_load),
      .clear   (a_clear),
      .capture (capture),
      .wdata   (a_wdata),
      .bus_in  (bus_in),
      .q       (a_q)
   );

   // 74x564, no clear and no capture path
   octal_register #(.BUS_W(BUS_W), .INVERT(1'b1)) reg_b (
      .clk     (clk),
      .rst     (rst),
      .load    (b_load),
      .clear   (1'b0),
      .capture (1'b0),
      .wdata   (b_wdata),
      .bus_in  ({BUS_W{1'b0}}),
      .q       (b_q)
   );

   transparent_latch #(.BUS_W(BUS_W)) u_latch (
      .clk      (clk),
      .rst      (rst),
      .latch_en (latch_en),
      .bus_in   (bus_in),
      .latch_q  (latch_q)
   );

   jk_flag_pair u_jk (
      .clk    (clk),
      .rst    (rst),
      .ctrl   (jk_ctrl),
      .jk_clk (jk_clk),
      .flags  (flags)
   );

endmodule

//--- src/chip_pkg.sv
package chip_pkg;

   ////////////////////////////////////////////////
   // Storage chip types
   ////////////////////////////////////////////////

   // One octal register word, as in the 74x273 / 74x564
   typedef logic [7:0] octal_t;

   // Control pins of one 74x112 half, bit 3 down to bit 0
   // Layout matches one JK_LEVEL nibble
   typedef struct packed {
      logic set_n;   // Active low preset
      logic rst_n;   // Active low clear
      logic j;
      logic k;
   } jk_ctrl_t;

   // Both outputs kept apart, they can go low together
   typedef struct packed {
      logic q;
      logic qn;
   } flag_t;

   // Idle pins, no forcing and JK hold
   localparam jk_ctrl_t JK_CTRL_IDLE = '{set_n: 1'b1, rst_n: 1'b1, j: 1'b0, k: 1'b0};

   ////////////////////////////////////////////////
   // Data bus source select
   ////////////////////////////////////////////////

   typedef logic [1:0] bus_sel_t;

   localparam bus_sel_t SEL_NONE  = 2'd0;  // Pulled up, reads all ones
   localparam bus_sel_t SEL_A     = 2'd1;  // 74x273 register
   localparam bus_sel_t SEL_B     = 2'd2;  // 74x564, inverted
   localparam bus_sel_t SEL_LATCH = 2'd3;  // 74x373 follower

endpackage

//--- src/jk_flag_pair.sv
`timescale 1ns/1ps

// Dual JK flag flip-flop after the 74x112
//
//   set_n rst_n | jk_clk | j k | q    qn
//   ------------+--------+-----+-----------
//     0     0   |   x    | x x | 0    0
//     0     1   |   x    | x x | 1    0
//     1     0   |   x    | x x | 0    1
//     1     1   |   1    | 0 0 | hold
//     1     1   |   1    | 0 1 | 0    1
//     1     1   |   1    | 1 0 | 1    0
//     1     1   |   1    | 1 1 | toggle
//     1     1   |   0    | x x | hold, qn re-synced to ~q
module jk_flag_pair (
   input  logic                   clk,
   input  logic                   rst,
   input  chip_pkg::jk_ctrl_t [1:0] ctrl,
   input  logic [1:0]             jk_clk,   // One-cycle edge per flop
   output chip_pkg::flag_t [1:0]  flags
);

   // q and qn held apart so the both-low state is visible
   logic [1:0] q_r;
   logic [1:0] qn_r;

   genvar i;

   generate
      for (i = 0; i < 2; i++) begin : g_flop

         ////////////////////////////////////////////////
         // One 74x112 half
         ////////////////////////////////////////////////

         always_ff @(posedge clk) begin
            if (!rst) begin
               q_r[i]  <= 1'b0;
               qn_r[i] <= 1'b1;
            end else begin
               case ({ctrl[i].set_n, ctrl[i].rst_n})
                  2'b00: begin          // Both forced, outputs both low
                     q_r[i]  <= 1'b0;
                     qn_r[i] <= 1'b0;
                  end
                  2'b01: begin          // Preset
                     q_r[i]  <= 1'b1;
                     qn_r[i] <= 1'b0;
                  end
                  2'b10: begin          // Clear
                     q_r[i]  <= 1'b0;
                     qn_r[i] <= 1'b1;
                  end
                  default: begin
                     // Released, qn follows whatever q was left at
                     qn_r[i] <= ~q_r[i];
                     if (jk_clk[i]) begin
                        case ({ctrl[i].j, ctrl[i].k})
                           2'b01: begin
                              q_r[i]  <= 1'b0;
                              qn_r[i] <= 1'b1;
                           end
                           2'b10: begin
                              q_r[i]  <= 1'b1;
                              qn_r[i] <= 1'b0;
                           end
                           2'b11: begin       // Toggle
                              q_r[i]  <= ~q_r[i];
                              qn_r[i] <= q_r[i];
                           end
                           default: ;         // Hold
                        endcase
                     end
                  end
               endcase
            end
         end

         assign flags[i].q  = q_r[i];
         assign flags[i].qn = qn_r[i];

         // Once released, outputs are complementary from the next edge on
         a_complement : assert property (
            @(posedge clk) disable iff (!rst)
            (ctrl[i].set_n && ctrl[i].rst_n) |=> (flags[i].qn == !flags[i].q)
         ) else $error("jk_flag_pair: flop %0d q/qn not complementary", i);

      end
   endgenerate

endmodule

//--- src/octal_register.sv
`timescale 1ns/1ps

// Octal D register, one model for both the 74x273 and the 74x564
// Priority: clear, then load, then capture
module octal_register #(
   parameter int BUS_W  = 8,
   parameter bit INVERT = 1'b0   // Set for the 74x564 style output
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             load,     // APB write of the register
   input  logic             clear,    // APB clear strobe
   input  logic             capture,  // External clock enable
   input  logic [BUS_W-1:0] wdata,
   input  logic [BUS_W-1:0] bus_in,
   output logic [BUS_W-1:0] q
);

   logic [BUS_W-1:0] stored;

   ////////////////////////////////////////////////
   // Storage
   ////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst) begin
         stored <= '0;
      end else if (clear) begin
         stored <= '0;          // Like /CLR on the 273
      end else if (load) begin
         stored <= wdata;       // APB access beats capture
      end else if (capture) begin
         stored <= bus_in;
      end
   end

   // Output stage
   // The 564 drives the complement of what it holds
   generate
      if (INVERT) begin : g_inv
         assign q = ~stored;
      end else begin : g_true
         assign q = stored;
      end
   endgenerate

   ////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////

   // Clear and load come from different offsets of one APB access,
   // so the regs block can never raise both
   a_clear_load_excl : assert property (
      @(posedge clk) disable iff (!rst)
      !(clear && load)
   ) else $error("octal_register: clear and load in the same cycle");

endmodule

//--- src/transparent_latch.sv
`timescale 1ns/1ps

// 74x373 latch bank as a clocked follower
// Enabled: samples bus_in each edge, so q trails the input by a cycle
// Disabled: holds the last sample
module transparent_latch #(
   parameter int BUS_W = 8
) (
   input  logic             clk,
   input  logic             rst,
   input  logic             latch_en,   // High is the transparent phase
   input  logic [BUS_W-1:0] bus_in,
   output logic [BUS_W-1:0] latch_q
);

   ////////////////////////////////////////////////
   // Follower register
   ////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (!rst) begin
         latch_q <= '0;
      end else if (latch_en) begin
         latch_q <= bus_in;   // Follow
      end
   end

   ////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////

   // Closed latch must not move, whatever bus_in does
   a_hold_when_closed : assert property (
      @(posedge clk) disable iff (!rst)
      !latch_en |=> $stable(latch_q)
   ) else $error("transparent_latch: latch_q moved while disabled");

endmodule

//--- test/tb_chip_bank_tasks.svh
//////////////////////////////////////////////////
// Helpers
//////////////////////////////////////////////////

task automatic check_value(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
   if (actual !== expected) begin
      fail_count++;
      $display("[FAIL] %s: got 0x%0h, expected 0x%0h", name, actual, expected);
      $display("Test failures found");
      $fatal(1, "Stopping at first mismatch");
   end
endtask

// Next random byte from the seeded stream
task automatic next_byte(output logic [7:0] b);
   integer r;
   r = $random(seed);
   b = r[7:0];
endtask

// Expected STATUS word with flags from bit 16 up as q0 qn0 q1 qn1
function automatic apb_pkg::data_t status_word(input logic [7:0] bus, input logic [7:0] lq,
                                               input logic q0, input logic qn0,
                                               input logic q1, input logic qn1);
   return {12'd0, qn1, q1, qn0, q0, lq, bus};
endfunction

// Setup then access phase with capture riding only the access cycle
task automatic apb_access(input logic wr, input apb_pkg::addr_t addr,
                          input apb_pkg::data_t wdata, input logic cap,
                          output apb_pkg::data_t rdata, output logic slverr);
   @(negedge clk);
   apb_req.psel    = 1'b1;
   apb_req.penable = 1'b0;
   apb_req.pwrite  = wr;
   apb_req.paddr   = addr;
   apb_req.pwdata  = wdata;
   @(negedge clk);
   apb_req.penable = 1'b1;
   capture         = cap;
   #(CLK_PERIOD / 4);          // Mid access so prdata has settled
   rdata  = apb_rsp.prdata;
   slverr = apb_rsp.pslverr;
   check_value("pready", apb_rsp.pready, 1'b1);
   @(negedge clk);             // Access edge now behind us
   apb_req = '0;
   capture = 1'b0;
endtask

task automatic apb_write(input apb_pkg::addr_t addr, input apb_pkg::data_t wdata);
   apb_pkg::data_t rd;
   logic           err;
   apb_access(1'b1, addr, wdata, 1'b0, rd, err);
   check_value("pslverr", err, 1'b0);
endtask

task automatic apb_read(input apb_pkg::addr_t addr, output apb_pkg::data_t rdata);
   logic err;
   apb_access(1'b0, addr, '0, 1'b0, rdata, err);
   check_value("pslverr", err, 1'b0);
endtask

// Flop 0 under test while flop 1 stays parked at q = 0
task automatic jk_apply(input logic [3:0] nib, input logic pulse,
                        input logic q, input logic qn);
   apb_write(apb_pkg::JK_LEVEL, {24'd0, JK_IDLE, nib});
   @(negedge clk);             // Forcing lands one edge later
   if (pulse) begin
      apb_write(apb_pkg::JK_PULSE, 32'h1);
      @(negedge clk);          // Registered pulse acts next edge
   end
   check_value("flags[0].q", flags[0].q, q);
   check_value("flags[0].qn", flags[0].qn, qn);
   check_value("flags[1].q", flags[1].q, 1'b0);
   check_value("flags[1].qn", flags[1].qn, 1'b1);
endtask

//////////////////////////////////////////////////
// Directed tests
//////////////////////////////////////////////////

task automatic test_reset();
   apb_pkg::data_t rd;
   check_value("data_bus", data_bus, 8'hFF);   // Pull-ups with nothing selected
   check_value("flags[0].q", flags[0].q, 1'b0);
   check_value("flags[0].qn", flags[0].qn, 1'b1);
   apb_read(apb_pkg::STATUS, rd);
   check_value("STATUS", rd, status_word(8'hFF, 8'h00, 1'b0, 1'b1, 1'b0, 1'b1));
endtask

task automatic test_regs_and_bus();
   apb_pkg::data_t rd;
   next_byte(exp_a);
   next_byte(exp_b);
   apb_write(apb_pkg::REG_A, {24'd0, exp_a});
   apb_write(apb_pkg::REG_B, {24'd0, exp_b});
   apb_read(apb_pkg::REG_A, rd);
   check_value("REG_A", rd, {24'd0, exp_a});
   apb_read(apb_pkg::REG_B, rd);
   check_value("REG_B", rd, {24'd0, exp_b});
   apb_write(apb_pkg::BUS_CTRL, {30'd0, chip_pkg::SEL_A});
   check_value("data_bus", data_bus, exp_a);
   apb_write(apb_pkg::BUS_CTRL, {30'd0, chip_pkg::SEL_B});
   check_value("data_bus", data_bus, 8'(~exp_b));  // 564 drives the complement
   apb_write(apb_pkg::CLEAR_A, 32'h1);
   exp_a = 8'h00;
   apb_write(apb_pkg::BUS_CTRL, {30'd0, chip_pkg::SEL_A});
   check_value("data_bus", data_bus, exp_a);
   apb_read(apb_pkg::REG_A, rd);
   check_value("REG_A", rd, {24'd0, exp_a});
endtask

task automatic test_capture();
   logic [7:0]     v;
   logic [7:0]     w;
   apb_pkg::data_t rd;
   logic           err;
   next_byte(v);
   bus_in  = v;                // Already on a falling edge with SEL_A active
   capture = 1'b1;
   @(negedge clk);
   capture = 1'b0;
   exp_a   = v;
   check_value("data_bus", data_bus, exp_a);
   // Capture on the APB write edge loses to the written value
   next_byte(v);
   next_byte(w);
   if (w == v) w = ~v;
   bus_in = v;
   apb_access(1'b1, apb_pkg::REG_A, {24'd0, w}, 1'b1, rd, err);
   exp_a = w;
   check_value("pslverr", err, 1'b0);
   check_value("data_bus", data_bus, exp_a);
endtask

task automatic test_latch();
   logic [7:0]     v;
   apb_pkg::data_t rd;
   apb_write(apb_pkg::BUS_CTRL, {29'd0, 1'b1, chip_pkg::SEL_LATCH});
   repeat (4) begin
      next_byte(v);
      bus_in = v;
      @(negedge clk);          // One edge of delay through the latch
      exp_latch = v;
      check_value("data_bus", data_bus, exp_latch);
   end
   apb_write(apb_pkg::BUS_CTRL, {30'd0, chip_pkg::SEL_LATCH});   // Close
   repeat (3) begin
      next_byte(v);
      bus_in = ~exp_latch ^ v; // Latch must hold whatever bus_in does
      @(negedge clk);
      check_value("data_bus", data_bus, exp_latch);
   end
   apb_read(apb_pkg::STATUS, rd);
   check_value("STATUS", rd, status_word(exp_latch, exp_latch, 1'b0, 1'b1, 1'b0, 1'b1));
endtask

task automatic test_jk_flags();
   apb_pkg::data_t rd;
   jk_apply(4'b1110, 1'b1, 1'b1, 1'b0);   // j = 1 set
   jk_apply(4'b1101, 1'b1, 1'b0, 1'b1);   // k = 1 clear
   jk_apply(4'b1111, 1'b1, 1'b1, 1'b0);   // Toggle up
   jk_apply(4'b1100, 1'b1, 1'b1, 1'b0);   // Hold
   jk_apply(4'b1111, 1'b1, 1'b0, 1'b1);   // Toggle down
   jk_apply(4'b0000, 1'b0, 1'b0, 1'b0);   // Both forced gives both low
   apb_read(apb_pkg::STATUS, rd);
   check_value("STATUS", rd, status_word(exp_latch, exp_latch, 1'b0, 1'b0, 1'b0, 1'b1));
   jk_apply(4'b0101, 1'b1, 1'b1, 1'b0);   // Clear pulse ignored under preset
   jk_apply(JK_IDLE, 1'b0, 1'b1, 1'b0);   // Release keeps q
endtask

task automatic test_apb_errors();
   apb_pkg::data_t rd;
   logic           err;
   apb_access(1'b1, 8'h20, 32'hFFFF_FFFF, 1'b0, rd, err);
   check_value("pslverr", err, 1'b1);
   apb_access(1'b0, 8'h1C, '0, 1'b0, rd, err);
   check_value("pslverr", err, 1'b1);
   check_value("prdata", rd, 32'h0);
   apb_read(apb_pkg::STATUS, rd);
   check_value("STATUS", rd, status_word(exp_latch, exp_latch, 1'b1, 1'b0, 1'b0, 1'b1));
   apb_read(apb_pkg::REG_A, rd);
   check_value("REG_A", rd, {24'd0, exp_a});
   apb_read(apb_pkg::REG_B, rd);
   check_value("REG_B", rd, {24'd0, exp_b});
endtask

//--- test/tb_chip_bank.sv
`timescale 1ns/1ps

module tb_chip_bank;

   localparam int BUS_W          = 8;
   localparam int CLK_PERIOD     = 40;
   localparam int TIMEOUT_CYCLES = 600;    // About four times the full sequence
   localparam logic [3:0] JK_IDLE = 4'b1100;   // set_n and rst_n high with j and k low

   logic                  clk;
   logic                  rst;
   apb_pkg::apb_req_t     apb_req;
   apb_pkg::apb_rsp_t     apb_rsp;
   logic [BUS_W-1:0]      bus_in;
   logic                  capture;
   logic [BUS_W-1:0]      data_bus;
   chip_pkg::flag_t [1:0] flags;

   integer     seed = 32'h36cf;
   int         fail_count = 0;
   int         cycle_count = 0;

   // Reference model of the stored values
   logic [7:0] exp_a;
   logic [7:0] exp_b;
   logic [7:0] exp_latch;

   //////////////////////////////////////////////////
   // Clock and timeout
   //////////////////////////////////////////////////

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d clock cycles", TIMEOUT_CYCLES);
         $display("Test failures found");
         $fatal(1, "Run aborted by timeout");
      end
   end

   //////////////////////////////////////////////////
   // DUT
   //////////////////////////////////////////////////

   chip_bank_top #(.BUS_W(BUS_W)) UUT (
      .clk      (clk),
      .rst      (rst),
      .apb_req  (apb_req),
      .apb_rsp  (apb_rsp),
      .bus_in   (bus_in),
      .capture  (capture),
      .data_bus (data_bus),
      .flags    (flags)
   );

   `include "tb_chip_bank_tasks.svh"

   //////////////////////////////////////////////////
   // Test sequence
   //////////////////////////////////////////////////

   initial begin
      apb_req   = '0;
      bus_in    = '0;
      capture   = 1'b0;
      rst       = 1'b0;     // Held through two rising edges
      exp_a     = 8'h00;
      exp_b     = 8'h00;
      exp_latch = 8'h00;
      repeat (2) @(negedge clk);
      rst = 1'b1;

      test_reset();
      test_regs_and_bus();
      test_capture();
      test_latch();
      test_jk_flags();
      test_apb_errors();

      if (fail_count == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

endmodule
